// ==== common/md_filter_pkg.sv ====
// Shared widths and pair types for the filter bank, imported by every filter and the arbiter
`default_nettype none

package md_filter_pkg;

	//////////////////////////////
	// Fixed widths
	//////////////////////////////

	// Signed fixed-point coordinate
	localparam int COORD_WIDTH = 16;
	// Particle ID, cell and slot packed together upstream
	localparam int PID_WIDTH   = 12;
	// Register stages through r2_compute
	localparam int R2_LATENCY  = 3;

	//////////////////////////////
	// Types
	//////////////////////////////

	typedef logic signed [COORD_WIDTH-1:0] coord_t;

	// One extra bit so neighbor minus reference never wraps
	typedef logic signed [COORD_WIDTH:0] delta_t;

	// Three squares of a 17-bit delta fit well inside 36 bits
	typedef logic [35:0] r2_t;

	typedef logic [PID_WIDTH-1:0] pid_t;

	// Buffer word, MSB first
	typedef struct packed {
		pid_t   ref_id;
		pid_t   nbr_id;
		r2_t    r2;
		delta_t dz;
		delta_t dy;
		delta_t dx;
	} pair_t;

endpackage

`default_nettype wire

// ==== common/pair_if.sv ====
// Link between one filter buffer and the round-robin arbiter, one instance per filter
`timescale 1ns/1ns
`default_nettype none

interface pair_if;

	import md_filter_pkg::*;

	// Oldest kept pair, valid while available is high
	pair_t head;

	// Buffer holds at least one pair
	logic available;

	// One-cycle pop, only while available
	logic pop;

	// Filter side presents the head and takes pops
	modport filter (
		output head,
		output available,
		input  pop
	);

	// Arbiter side picks a filter and pops it
	modport arbiter (
		input  head,
		input  available,
		output pop
	);

endinterface

`default_nettype wire

// ==== hw/filter/r2_compute.sv ====
// Three-stage displacement and squared-distance pipeline used inside each filter
`timescale 1ns/1ns
`default_nettype none

module r2_compute (
	input  logic                clk,
	input  logic                rst,
	input  logic                enable,
	input  md_filter_pkg::coord_t refx,
	input  md_filter_pkg::coord_t refy,
	input  md_filter_pkg::coord_t refz,
	input  md_filter_pkg::coord_t nbrx,
	input  md_filter_pkg::coord_t nbry,
	input  md_filter_pkg::coord_t nbrz,
	output md_filter_pkg::delta_t dx,
	output md_filter_pkg::delta_t dy,
	output md_filter_pkg::delta_t dz,
	output md_filter_pkg::r2_t    r2,
	output logic                r2_valid
);

	import md_filter_pkg::*;

	// Stage one, displacements
	delta_t dx_s1, dy_s1, dz_s1;
	logic   valid_s1;

	// Stage two, squares plus displacements carried along
	r2_t    sq_x, sq_y, sq_z;
	delta_t dx_s2, dy_s2, dz_s2;
	logic   valid_s2;

	//////////////////////////////
	// Valid bits
	//////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			valid_s1 <= 1'b0;
			valid_s2 <= 1'b0;
			r2_valid <= 1'b0;
		end
		else
		begin
			valid_s1 <= enable;
			valid_s2 <= valid_s1;
			r2_valid <= valid_s2;
		end
	end

	//////////////////////////////
	// Datapath
	//////////////////////////////
	always_ff @(posedge clk)
	begin
		// Neighbor minus reference, sign-extended first
		dx_s1 <= delta_t'(nbrx) - delta_t'(refx);
		dy_s1 <= delta_t'(nbry) - delta_t'(refy);
		dz_s1 <= delta_t'(nbrz) - delta_t'(refz);
		// Signed operands widened to 36 bits by the target
		sq_x  <= dx_s1 * dx_s1;
		sq_y  <= dy_s1 * dy_s1;
		sq_z  <= dz_s1 * dz_s1;
		dx_s2 <= dx_s1;
		dy_s2 <= dy_s1;
		dz_s2 <= dz_s1;
		// Sum stage, deltas leave with their r2
		r2    <= sq_x + sq_y + sq_z;
		dx    <= dx_s2;
		dy    <= dy_s2;
		dz    <= dz_s2;
	end

endmodule

`default_nettype wire

// ==== hw/filter/filter_buffer.sv ====
// Show-ahead FIFO holding kept pairs of one filter until the arbiter drains them
`timescale 1ns/1ns
`default_nettype none

module filter_buffer #(
	parameter int DEPTH = 16
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       wr,
	input  md_filter_pkg::pair_t       wr_data,
	input  logic                       rd,
	output md_filter_pkg::pair_t       q,
	output logic                       empty,
	output logic [$clog2(DEPTH+1)-1:0] usedw
);

	import md_filter_pkg::*;

	localparam int ADDR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int COUNT_W = $clog2(DEPTH+1);

	// Pair storage
	pair_t mem [DEPTH];

	logic [ADDR_W-1:0]  wr_ptr;
	logic [ADDR_W-1:0]  rd_ptr;
	logic [COUNT_W-1:0] count;

	// Qualified requests
	logic do_wr;
	logic do_rd;

	assign do_wr = wr && (int'(count) < DEPTH);
	assign do_rd = rd && (count != '0);

	// Oldest entry always on q
	assign q     = mem[rd_ptr];
	assign empty = (count == '0);
	assign usedw = count;

	//////////////////////////////
	// Pointers and count
	//////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= (int'(wr_ptr) == DEPTH-1) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (int'(rd_ptr) == DEPTH-1) ? '0 : rd_ptr + 1'b1;
			// Read and write together keep the level
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (do_rd && !do_wr)
				count <= count - 1'b1;
		end
	end

	// RAM write port
	always_ff @(posedge clk)
	begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

endmodule

`default_nettype wire

// ==== hw/filter/filter_logic.sv ====
// One cutoff filter: distance pipeline, ID delay, keep test, buffer and back-pressure
`timescale 1ns/1ns
`default_nettype none

module filter_logic #(
	parameter int                 BUFFER_DEPTH = 16,
	parameter md_filter_pkg::r2_t CUTOFF_2     = 400
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  input_valid,
	input  md_filter_pkg::pid_t   ref_id,
	input  md_filter_pkg::pid_t   nbr_id,
	input  md_filter_pkg::coord_t refx,
	input  md_filter_pkg::coord_t refy,
	input  md_filter_pkg::coord_t refz,
	input  md_filter_pkg::coord_t nbrx,
	input  md_filter_pkg::coord_t nbry,
	input  md_filter_pkg::coord_t nbrz,
	output logic                  back_pressure,
	pair_if.filter                port
);

	import md_filter_pkg::*;

	localparam int USEDW_W = $clog2(BUFFER_DEPTH+1);
	// Room kept free for every pair still in flight
	localparam int BP_LEVEL = BUFFER_DEPTH - (R2_LATENCY + 2);

	// Pipeline results
	delta_t res_dx, res_dy, res_dz;
	r2_t    res_r2;
	logic   res_valid;

	// ID delay, one deeper than r2_compute to meet the write register
	pid_t ref_pipe [R2_LATENCY+1];
	pid_t nbr_pipe [R2_LATENCY+1];

	// Registered buffer write
	logic   buf_wr;
	r2_t    buf_r2;
	delta_t buf_dx, buf_dy, buf_dz;
	pair_t  buf_word;

	logic               buf_empty;
	logic [USEDW_W-1:0] buf_usedw;

	r2_compute u_r2 (
		.clk      (clk),
		.rst      (rst),
		.enable   (input_valid),
		.refx     (refx),
		.refy     (refy),
		.refz     (refz),
		.nbrx     (nbrx),
		.nbry     (nbry),
		.nbrz     (nbrz),
		.dx       (res_dx),
		.dy       (res_dy),
		.dz       (res_dz),
		.r2       (res_r2),
		.r2_valid (res_valid)
	);

	//////////////////////////////
	// ID delay line
	//////////////////////////////
	always_ff @(posedge clk)
	begin
		ref_pipe[0] <= ref_id;
		nbr_pipe[0] <= nbr_id;
		for (int i = 1; i <= R2_LATENCY; i++)
		begin
			ref_pipe[i] <= ref_pipe[i-1];
			nbr_pipe[i] <= nbr_pipe[i-1];
		end
	end

	//////////////////////////////
	// Cutoff test
	//////////////////////////////
	// Zero distance means a self pair
	always_ff @(posedge clk)
	begin
		if (rst)
			buf_wr <= 1'b0;
		else
			buf_wr <= res_valid && (res_r2 != '0) && (res_r2 < CUTOFF_2);
	end

	always_ff @(posedge clk)
	begin
		buf_r2 <= res_r2;
		buf_dx <= res_dx;
		buf_dy <= res_dy;
		buf_dz <= res_dz;
	end

	// IDs from the last delay stage line up here
	assign buf_word.ref_id = ref_pipe[R2_LATENCY];
	assign buf_word.nbr_id = nbr_pipe[R2_LATENCY];
	assign buf_word.r2     = buf_r2;
	assign buf_word.dz     = buf_dz;
	assign buf_word.dy     = buf_dy;
	assign buf_word.dx     = buf_dx;

	filter_buffer #(
		.DEPTH (BUFFER_DEPTH)
	) u_buffer (
		.clk     (clk),
		.rst     (rst),
		.wr      (buf_wr),
		.wr_data (buf_word),
		.rd      (port.pop),
		.q       (port.head),
		.empty   (buf_empty),
		.usedw   (buf_usedw)
	);

	assign port.available = !buf_empty;
	assign back_pressure  = int'(buf_usedw) >= BP_LEVEL;

endmodule

`default_nettype wire

// ==== hw/filter_arbiter.sv ====
// Round-robin drain of the filter buffers into the single force-pipeline port
`timescale 1ns/1ns
`default_nettype none

module filter_arbiter #(
	parameter int NUM_FILTERS = 2
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 force_ready,
	pair_if.arbiter              ports [NUM_FILTERS],
	output logic                 pair_valid,
	output md_filter_pkg::pair_t pair_out
);

	import md_filter_pkg::*;

	localparam int PTR_W = (NUM_FILTERS > 1) ? $clog2(NUM_FILTERS) : 1;

	logic [NUM_FILTERS-1:0] avail;
	pair_t                  heads [NUM_FILTERS];

	// Filter searched first
	logic [PTR_W-1:0] rr_ptr;
	logic [PTR_W-1:0] grant;
	logic             found;
	logic             take;

	// Flatten the interface array
	for (genvar g = 0; g < NUM_FILTERS; g++)
	begin : g_port
		assign avail[g]     = ports[g].available;
		assign heads[g]     = ports[g].head;
		assign ports[g].pop = take && (int'(grant) == g);
	end

	//////////////////////////////
	// Round-robin search
	//////////////////////////////
	always_comb
	begin
		int idx;
		found = 1'b0;
		grant = '0;
		for (int i = 0; i < NUM_FILTERS; i++)
		begin
			idx = (int'(rr_ptr) + i) % NUM_FILTERS;
			if (!found && avail[idx])
			begin
				found = 1'b1;
				grant = PTR_W'(idx);
			end
		end
	end

	// Pop only toward a ready force pipeline
	assign take = force_ready && found;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rr_ptr     <= '0;
			pair_valid <= 1'b0;
		end
		else
		begin
			pair_valid <= take;
			// Next search starts after the served filter
			if (take)
				rr_ptr <= (int'(grant) == NUM_FILTERS-1) ? '0 : grant + 1'b1;
		end
	end

	// Output record, held until the next pop
	always_ff @(posedge clk)
	begin
		if (take)
			pair_out <= heads[grant];
	end

endmodule

`default_nettype wire

// ==== hw/filter_bank.sv ====
// Top level of the pair filter bank, per-filter input ports and one force-pipeline output
`timescale 1ns/1ns
`default_nettype none

module filter_bank #(
	parameter int                 NUM_FILTERS  = 2,
	parameter int                 BUFFER_DEPTH = 16,
	parameter md_filter_pkg::r2_t CUTOFF_2     = 400
) (
	input  logic                   clk,
	input  logic                   rst,

	// Input generator side, one entry per filter
	input  logic [NUM_FILTERS-1:0] in_valid,
	input  md_filter_pkg::pid_t    in_ref_id [NUM_FILTERS],
	input  md_filter_pkg::pid_t    in_nbr_id [NUM_FILTERS],
	input  md_filter_pkg::coord_t  in_refx   [NUM_FILTERS],
	input  md_filter_pkg::coord_t  in_refy   [NUM_FILTERS],
	input  md_filter_pkg::coord_t  in_refz   [NUM_FILTERS],
	input  md_filter_pkg::coord_t  in_nbrx   [NUM_FILTERS],
	input  md_filter_pkg::coord_t  in_nbry   [NUM_FILTERS],
	input  md_filter_pkg::coord_t  in_nbrz   [NUM_FILTERS],
	output logic [NUM_FILTERS-1:0] back_pressure,

	// Force pipeline side
	input  logic                   force_ready,
	output logic                   pair_valid,
	output md_filter_pkg::pid_t    pair_ref_id,
	output md_filter_pkg::pid_t    pair_nbr_id,
	output md_filter_pkg::r2_t     pair_r2,
	output md_filter_pkg::delta_t  pair_dx,
	output md_filter_pkg::delta_t  pair_dy,
	output md_filter_pkg::delta_t  pair_dz
);

	import md_filter_pkg::*;

	// One link per filter
	pair_if pif [NUM_FILTERS] ();

	pair_t pair_out;

	//////////////////////////////
	// Filters
	//////////////////////////////
	for (genvar g = 0; g < NUM_FILTERS; g++)
	begin : g_filter
		filter_logic #(
			.BUFFER_DEPTH (BUFFER_DEPTH),
			.CUTOFF_2     (CUTOFF_2)
		) u_filter (
			.clk           (clk),
			.rst           (rst),
			.input_valid   (in_valid[g]),
			.ref_id        (in_ref_id[g]),
			.nbr_id        (in_nbr_id[g]),
			.refx          (in_refx[g]),
			.refy          (in_refy[g]),
			.refz          (in_refz[g]),
			.nbrx          (in_nbrx[g]),
			.nbry          (in_nbry[g]),
			.nbrz          (in_nbrz[g]),
			.back_pressure (back_pressure[g]),
			.port          (pif[g])
		);
	end

	// Single drain toward the force pipeline
	filter_arbiter #(
		.NUM_FILTERS (NUM_FILTERS)
	) u_arbiter (
		.clk         (clk),
		.rst         (rst),
		.force_ready (force_ready),
		.ports       (pif),
		.pair_valid  (pair_valid),
		.pair_out    (pair_out)
	);

	// Split the record onto the plain ports
	assign pair_ref_id = pair_out.ref_id;
	assign pair_nbr_id = pair_out.nbr_id;
	assign pair_r2     = pair_out.r2;
	assign pair_dx     = pair_out.dx;
	assign pair_dy     = pair_out.dy;
	assign pair_dz     = pair_out.dz;

endmodule

`default_nettype wire

// ==== test/filter_bank_assert.sv ====
// Concurrent protocol checks on the filter bank top level, attached to every filter_bank by bind
`timescale 1ns/1ns
`default_nettype none

module filter_bank_assert #(
	parameter int                 NUM_FILTERS = 2,
	parameter md_filter_pkg::r2_t CUTOFF_2    = 400
) (
	input logic                    clk,
	input logic                    rst,
	input logic                    pair_valid,
	input md_filter_pkg::r2_t      pair_r2,
	input logic [NUM_FILTERS-1:0] back_pressure,
	pair_if                        pif [NUM_FILTERS]
);

	// Output quiet once reset has taken hold
	a_valid_in_reset: assert property (@(posedge clk) rst && $past(rst) |-> !pair_valid)
		else $error("pair_valid high during reset");

	// Forwarded pairs lie strictly inside the cutoff
	a_r2_range: assert property (@(posedge clk) disable iff (rst)
		pair_valid |-> (pair_r2 != '0) && (pair_r2 < CUTOFF_2))
		else $error("pair_r2 %0d outside the cutoff window", pair_r2);

	// Empty buffers right after reset
	a_bp_after_reset: assert property (@(posedge clk) $fell(rst) |-> back_pressure == '0)
		else $error("back_pressure high right after reset");

	//////////////////////////////
	// Per-filter pop rule
	//////////////////////////////
	for (genvar g = 0; g < NUM_FILTERS; g++)
	begin : g_pop
		a_pop_avail: assert property (@(posedge clk) disable iff (rst)
			pif[g].pop |-> pif[g].available)
			else $error("pop without available on filter %0d", g);
	end

endmodule

bind filter_bank filter_bank_assert #(
	.NUM_FILTERS (NUM_FILTERS),
	.CUTOFF_2    (CUTOFF_2)
) u_assert (
	.clk           (clk),
	.rst           (rst),
	.pair_valid    (pair_valid),
	.pair_r2       (pair_r2),
	.back_pressure (back_pressure),
	.pif           (pif)
);

`default_nettype wire

// ==== test/tb_filter_bank.sv ====
// Table-driven testbench for the filter bank that runs as top module tb_filter_bank with a per-filter scoreboard
`timescale 1ns/1ns
`default_nettype none

module tb_filter_bank;

	import md_filter_pkg::*;

	localparam int  NF          = 2;
	localparam r2_t CUTOFF      = 400;
	localparam int  N_DIRECTED  = 8;
	localparam int  N_RANDOM    = 40;
	localparam int  N_BURST     = 18;
	localparam int  N_ROT       = 10;
	localparam int  NUM_ENTRIES = N_DIRECTED + N_RANDOM + N_BURST + N_ROT;
	localparam int  CYCLE_LIMIT = NUM_ENTRIES * (NF + 8) + 200;

	// One stimulus row with its expected result
	typedef struct packed {
		int     filt;
		pid_t   ref_id;
		pid_t   nbr_id;
		coord_t refx;
		coord_t refy;
		coord_t refz;
		coord_t nbrx;
		coord_t nbry;
		coord_t nbrz;
		delta_t dx;
		delta_t dy;
		delta_t dz;
		r2_t    r2;
		logic   keep;
	} entry_t;

	logic          clk;
	logic          rst;
	logic [NF-1:0] in_valid;
	pid_t          in_ref_id [NF];
	pid_t          in_nbr_id [NF];
	coord_t        in_refx [NF];
	coord_t        in_refy [NF];
	coord_t        in_refz [NF];
	coord_t        in_nbrx [NF];
	coord_t        in_nbry [NF];
	coord_t        in_nbrz [NF];
	logic [NF-1:0] back_pressure;
	logic          force_ready;
	logic          pair_valid;
	pid_t          pair_ref_id;
	pid_t          pair_nbr_id;
	r2_t           pair_r2;
	delta_t        pair_dx;
	delta_t        pair_dy;
	delta_t        pair_dz;

	entry_t tbl [NUM_ENTRIES];
	string  tbl_name [NUM_ENTRIES];
	int     n_entries = 0;

	// Table indices still owed by each filter in arrival order
	int exp_q [NF][$];

	// Times each table row showed up on the output
	int seen [NUM_ENTRIES];

	int     errors = 0;
	int     passed = 0;
	int     out_count = 0;
	int     kept_count = 0;
	int     stall_cycles = 0;
	int     cycles;
	integer seed;

	// Round-robin check state
	logic rot_check = 1'b0;
	logic have_last = 1'b0;
	int   last_f;

	filter_bank dut0 (
		.clk           (clk),
		.rst           (rst),
		.in_valid      (in_valid),
		.in_ref_id     (in_ref_id),
		.in_nbr_id     (in_nbr_id),
		.in_refx       (in_refx),
		.in_refy       (in_refy),
		.in_refz       (in_refz),
		.in_nbrx       (in_nbrx),
		.in_nbry       (in_nbry),
		.in_nbrz       (in_nbrz),
		.back_pressure (back_pressure),
		.force_ready   (force_ready),
		.pair_valid    (pair_valid),
		.pair_ref_id   (pair_ref_id),
		.pair_nbr_id   (pair_nbr_id),
		.pair_r2       (pair_r2),
		.pair_dx       (pair_dx),
		.pair_dy       (pair_dy),
		.pair_dz       (pair_dz)
	);

	// 4 ns period
	initial clk = 1'b0;
	always #2 clk = ~clk;

	//////////////////////////////
	// Compare tasks
	//////////////////////////////
	task automatic check_pid(input string name, input string what, input pid_t exp,
		input pid_t act);
		if (exp !== act)
		begin
			$display("[FAIL] %s %s expected %0d actual %0d", name, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_delta(input string name, input string what, input delta_t exp,
		input delta_t act);
		if (exp !== act)
		begin
			$display("[FAIL] %s %s expected %0d actual %0d", name, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_r2(input string name, input r2_t exp, input r2_t act);
		if (exp !== act)
		begin
			$display("[FAIL] %s r2 expected %0d actual %0d", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input string what, input logic exp,
		input logic act);
		if (exp !== act)
		begin
			$display("[FAIL] %s %s expected %b actual %b", name, what, exp, act);
			errors++;
		end
	endtask

	//////////////////////////////
	// Table construction
	//////////////////////////////
	// IDs carry the filter index in bits 11:10
	task automatic add_entry(input string name, input int f, input int rx, input int ry,
		input int rz, input int nx, input int ny, input int nz);
		longint ddx;
		longint ddy;
		longint ddz;
		longint sum;
		entry_t e;
		e.filt   = f;
		e.ref_id = pid_t'(f * 1024 + n_entries);
		e.nbr_id = pid_t'(f * 1024 + 512 + n_entries);
		e.refx   = coord_t'(rx);
		e.refy   = coord_t'(ry);
		e.refz   = coord_t'(rz);
		e.nbrx   = coord_t'(nx);
		e.nbry   = coord_t'(ny);
		e.nbrz   = coord_t'(nz);
		// Neighbor minus reference on the stored coordinates
		ddx      = longint'(e.nbrx) - longint'(e.refx);
		ddy      = longint'(e.nbry) - longint'(e.refy);
		ddz      = longint'(e.nbrz) - longint'(e.refz);
		sum      = ddx * ddx + ddy * ddy + ddz * ddz;
		e.dx     = delta_t'(ddx);
		e.dy     = delta_t'(ddy);
		e.dz     = delta_t'(ddz);
		e.r2     = r2_t'(sum);
		e.keep   = (sum > 0) && (sum < longint'(CUTOFF));
		tbl[n_entries]      = e;
		tbl_name[n_entries] = name;
		n_entries++;
	endtask

	task automatic build_table();
		int f;
		int rx;
		int ry;
		int rz;
		int ox;
		int oy;
		int oz;
		add_entry("close_pair",   0, 100, 200, 300, 101, 202, 303);
		add_entry("self_pair",    1, 50, -50, 7, 50, -50, 7);
		add_entry("on_cutoff",    0, 0, 0, 0, 20, 0, 0);
		add_entry("inside_edge",  1, -10, -10, -10, 9, -4, -9);
		add_entry("neg_delta",    0, 500, 500, 500, 490, 495, 497);
		add_entry("far_pair",     1, -32768, 0, 32767, 32767, 0, -32768);
		add_entry("one_axis",     1, 1, 1, 1, 1, 1, 20);
		add_entry("outside_diag", 0, 0, 0, 0, 12, 12, 12);
		// Offsets up to 15 per axis give a mix around the cutoff
		for (int i = 0; i < N_RANDOM; i++)
		begin
			f  = $random(seed) & 1;
			rx = $random(seed) % 8192;
			ry = $random(seed) % 8192;
			rz = $random(seed) % 8192;
			ox = $random(seed) % 16;
			oy = $random(seed) % 16;
			oz = $random(seed) % 16;
			add_entry($sformatf("rand_%0d", i), f, rx, ry, rz, rx + ox, ry + oy, rz + oz);
		end
		// Burst into filter 0 with every pair kept
		for (int i = 0; i < N_BURST; i++)
			add_entry($sformatf("burst_%0d", i), 0, 1000 + i, -2000, 3000,
				1001 + i + i % 5, -1998, 2997);
		// Even split for the rotation check
		for (int i = 0; i < N_ROT; i++)
			add_entry($sformatf("rot_%0d", i), i % 2, 3 * i, 7, -7, 3 * i + 4, 7 + i % 3, -6);
	endtask

	//////////////////////////////
	// Stimulus
	//////////////////////////////
	// One row per falling edge held off while its filter pushes back
	task automatic apply_entries(input int first, input int last);
		int f;
		for (int k = first; k < last; k++)
		begin
			f = tbl[k].filt;
			@(negedge clk);
			in_valid = '0;
			while (back_pressure[f])
			begin
				stall_cycles++;
				@(negedge clk);
			end
			in_ref_id[f] = tbl[k].ref_id;
			in_nbr_id[f] = tbl[k].nbr_id;
			in_refx[f]   = tbl[k].refx;
			in_refy[f]   = tbl[k].refy;
			in_refz[f]   = tbl[k].refz;
			in_nbrx[f]   = tbl[k].nbrx;
			in_nbry[f]   = tbl[k].nbry;
			in_nbrz[f]   = tbl[k].nbrz;
			in_valid[f]  = 1'b1;
			if (tbl[k].keep)
			begin
				exp_q[f].push_back(k);
				kept_count++;
			end
		end
		@(negedge clk);
		in_valid = '0;
	endtask

	// Reopen the force pipeline a few cycles after filter 0 pushes back
	task automatic resume_after_bp();
		while (!back_pressure[0])
			@(negedge clk);
		repeat (6) @(negedge clk);
		force_ready = 1'b1;
	endtask

	function automatic int pending_pairs();
		int n;
		n = 0;
		for (int g = 0; g < NF; g++)
			n += exp_q[g].size();
		return n;
	endfunction

	task automatic wait_queues_empty();
		while (pending_pairs() != 0)
			@(negedge clk);
	endtask

	//////////////////////////////
	// Output monitor
	//////////////////////////////
	always @(negedge clk)
	begin
		int f;
		int k;
		int idx;
		int errs_before;
		if (!rst && pair_valid)
		begin
			out_count++;
			// Low ID bits give the table row
			idx = int'(pair_ref_id) % 1024;
			if (idx < NUM_ENTRIES)
				seen[idx]++;
			f = int'(pair_ref_id) / 1024;
			if (f >= NF || exp_q[f].size() == 0)
			begin
				$display("Unexpected pair on the output, ref_id %0d nbr_id %0d",
					pair_ref_id, pair_nbr_id);
				errors++;
			end
			else
			begin
				// Same filter twice while another one waits breaks the rotation
				if (rot_check && have_last && last_f == f)
					for (int g = 0; g < NF; g++)
						if (g != f && exp_q[g].size() != 0)
						begin
							$display("Filter %0d served twice in a row while filter %0d waited",
								f, g);
							errors++;
						end
				k = exp_q[f].pop_front();
				errs_before = errors;
				check_pid(tbl_name[k], "ref_id", tbl[k].ref_id, pair_ref_id);
				check_pid(tbl_name[k], "nbr_id", tbl[k].nbr_id, pair_nbr_id);
				check_delta(tbl_name[k], "dx", tbl[k].dx, pair_dx);
				check_delta(tbl_name[k], "dy", tbl[k].dy, pair_dy);
				check_delta(tbl_name[k], "dz", tbl[k].dz, pair_dz);
				check_r2(tbl_name[k], tbl[k].r2, pair_r2);
				if (errors == errs_before)
				begin
					passed++;
					$display("[PASS] %s", tbl_name[k]);
				end
				last_f    = f;
				have_last = 1'b1;
			end
		end
	end

	//////////////////////////////
	// Watchdog
	//////////////////////////////
	initial
	begin : watchdog
		cycles = 0;
		while (cycles < CYCLE_LIMIT)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout, the run did not complete within %0d cycles", CYCLE_LIMIT);
		$display("** FAIL **");
		$finish;
	end

	//////////////////////////////
	// Main sequence
	//////////////////////////////
	initial
	begin
		int errs_before;
		int burst0;
		int rot0;
		seed        = 64;
		rst         = 1'b1;
		force_ready = 1'b0;
		in_valid    = '0;
		for (int g = 0; g < NF; g++)
		begin
			in_ref_id[g] = '0;
			in_nbr_id[g] = '0;
			in_refx[g]   = '0;
			in_refy[g]   = '0;
			in_refz[g]   = '0;
			in_nbrx[g]   = '0;
			in_nbry[g]   = '0;
			in_nbrz[g]   = '0;
		end
		build_table();
		burst0 = N_DIRECTED + N_RANDOM;
		rot0   = burst0 + N_BURST;

		repeat (8) @(posedge clk);
		@(negedge clk);
		rst         = 1'b0;
		force_ready = 1'b1;

		// Idle bank after reset
		errs_before = errors;
		repeat (4)
		begin
			@(negedge clk);
			check_flag("reset_idle", "pair_valid", 1'b0, pair_valid);
			for (int g = 0; g < NF; g++)
				check_flag("reset_idle", $sformatf("back_pressure[%0d]", g), 1'b0,
					back_pressure[g]);
		end
		if (errors == errs_before)
		begin
			passed++;
			$display("[PASS] reset_idle");
		end

		// Directed and random rows with the force pipeline always ready
		apply_entries(0, burst0);
		wait_queues_empty();

		// Stalled force pipeline during a burst
		@(negedge clk);
		force_ready  = 1'b0;
		stall_cycles = 0;
		fork
			apply_entries(burst0, rot0);
			resume_after_bp();
		join
		wait_queues_empty();
		if (stall_cycles == 0)
		begin
			$display("Back-pressure never held the stimulus during the stalled burst");
			errors++;
		end
		else
		begin
			passed++;
			$display("[PASS] bp_burst, stimulus held for %0d cycles", stall_cycles);
		end

		// Fill both filters and drain with the rotation check on
		@(negedge clk);
		force_ready = 1'b0;
		apply_entries(rot0, NUM_ENTRIES);
		repeat (R2_LATENCY + 3) @(negedge clk);
		errs_before = errors;
		have_last   = 1'b0;
		rot_check   = 1'b1;
		force_ready = 1'b1;
		wait_queues_empty();
		rot_check = 1'b0;
		if (errors == errs_before)
		begin
			passed++;
			$display("[PASS] round_robin");
		end

		// Let any stray output show up
		repeat (10) @(negedge clk);
		for (int k = 0; k < n_entries; k++)
			if (!tbl[k].keep)
			begin
				if (seen[k] != 0)
				begin
					$display("Dropped pair %s reached the output %0d times", tbl_name[k],
						seen[k]);
					errors++;
				end
				else
				begin
					passed++;
					$display("[PASS] %s filtered out", tbl_name[k]);
				end
			end
		if (out_count != kept_count)
		begin
			$display("Output count %0d differs from the %0d kept pairs", out_count, kept_count);
			errors++;
		end

		$display("Done: %0d passed, %0d errors, %0d of %0d kept pairs delivered",
			passed, errors, out_count, kept_count);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
common/md_filter_pkg.sv
common/pair_if.sv
hw/filter/r2_compute.sv
hw/filter/filter_buffer.sv
hw/filter/filter_logic.sv
hw/filter_arbiter.sv
hw/filter_bank.sv
test/filter_bank_assert.sv
test/tb_filter_bank.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_filter_bank
FLIST     := flist.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := ** PASS **

SOURCES := $(shell cat $(FLIST))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
